//--- hdl/batchTypesPkg.sv
package batchTypesPkg;

    localparam int IN_BITS = 2;
    localparam int OSR = 2;
    localparam int WORD_BITS = IN_BITS * OSR;
    localparam int BATCH_WORDS = 8;
    localparam int BANKS = 4;
    localparam int CHANNELS = 2;
    localparam int PART_BUFS = 2;

    // Q6.14 signed fixed point
    localparam int FIX_BITS = 20;
    localparam int FRAC_BITS = 14;

    // Batch periods until the first part buffer holds real data
    localparam int START_PERIODS = 4;

    typedef logic [IN_BITS-1:0] sdT;
    typedef logic [WORD_BITS-1:0] sampleWordT;
    typedef logic [$clog2(BATCH_WORDS)-1:0] addrT;
    typedef logic [$clog2(BANKS)-1:0] bankT;
    typedef logic signed [FIX_BITS-1:0] fixT;

    typedef enum logic {
        FILLING,
        RUNNING
    } ctrlStateT;

    // Full product, realigned and truncated back to FIX_BITS
    function automatic fixT fixMul(input fixT a, input fixT b);
        logic signed [2*FIX_BITS-1:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: FIX_BITS];
    endfunction

    function automatic fixT cplxRe(input fixT aRe, input fixT aIm, input fixT bRe, input fixT bIm);
        return fixMul(aRe, bRe) - fixMul(aIm, bIm);
    endfunction

    function automatic fixT cplxIm(input fixT aRe, input fixT aIm, input fixT bRe, input fixT bIm);
        return fixMul(aRe, bIm) + fixMul(aIm, bRe);
    endfunction

endpackage

//--- hdl/batchCoeffPkg.sv
package batchCoeffPkg;

    import batchTypesPkg::*;

    // Per-bit contribution of a sample word, index [channel][bit]
    localparam fixT fwdBitCoefRe [CHANNELS][WORD_BITS] = '{
        '{1966, 1475, 983, 492},
        '{1638, -1147, 819, 1311}
    };
    localparam fixT fwdBitCoefIm [CHANNELS][WORD_BITS] = '{
        '{-655, 819, -328, 1147},
        '{492, 983, -819, 328}
    };

    // Also used by the lookahead pass
    localparam fixT bwdBitCoefRe [CHANNELS][WORD_BITS] = '{
        '{1802, 1311, -819, 655},
        '{1475, 983, 1147, -492}
    };
    localparam fixT bwdBitCoefIm [CHANNELS][WORD_BITS] = '{
        '{328, -983, 492, 819},
        '{-819, 655, 328, 983}
    };

    // Pole to the power OSR, one step per sample word
    localparam fixT fwdFactorRe [CHANNELS] = '{13107, 11469};
    localparam fixT fwdFactorIm [CHANNELS] = '{4915, -7373};
    localparam fixT bwdFactorRe [CHANNELS] = '{12780, 10813};
    localparam fixT bwdFactorIm [CHANNELS] = '{-5243, 6554};

    // Complex output weights
    localparam fixT fwdWeightRe [CHANNELS] = '{7373, 5734};
    localparam fixT fwdWeightIm [CHANNELS] = '{-3277, 4096};
    localparam fixT bwdWeightRe [CHANNELS] = '{6554, 4915};
    localparam fixT bwdWeightIm [CHANNELS] = '{2458, -3604};

endpackage

//--- hdl/batchCtrlIf.sv
`timescale 1ns/1ns

interface batchCtrlIf import batchTypesPkg::*; ();

    logic dsEn;
    bankT wrBank;
    addrT wrAddr;
    bankT laBank;
    bankT procBank;
    addrT fwdAddr;
    addrT revAddr;
    logic batchStart;
    logic partSel;
    logic outEn;

    modport ctrl (
        output dsEn, wrBank, wrAddr, laBank, procBank, fwdAddr, revAddr,
        output batchStart, partSel, outEn
    );

    modport banks (
        input dsEn, wrBank, wrAddr, laBank, procBank, fwdAddr, revAddr
    );

    modport chan (
        input dsEn, fwdAddr, revAddr, batchStart, partSel
    );

endinterface

//--- hdl/batchControl.sv
`timescale 1ns/1ns

module batchControl import batchTypesPkg::*; (
    input logic clk,
    input logic rstN,
    batchCtrlIf.ctrl ctl
);

    logic [$clog2(OSR)-1:0] osrCnt;
    addrT stepCnt;
    bankT periodCnt;
    logic [$clog2(START_PERIODS)-1:0] fillCnt;
    ctrlStateT state;
    logic lastStep;

    // One sample step every OSR clocks
    assign ctl.dsEn = (osrCnt == OSR - 1);
    assign lastStep = (stepCnt == addrT'(BATCH_WORDS - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            osrCnt <= '0;
            stepCnt <= '0;
            periodCnt <= '0;
        end else if (ctl.dsEn) begin
            osrCnt <= '0;
            if (lastStep) begin
                stepCnt <= '0;
                periodCnt <= periodCnt + 1'b1;
            end else begin
                stepCnt <= stepCnt + 1'b1;
            end
        end else begin
            osrCnt <= osrCnt + 1'b1;
        end
    end

    // Startup until every bank and part buffer has seen real data
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= FILLING;
            fillCnt <= '0;
        end else if (ctl.dsEn && lastStep && state == FILLING) begin
            if (fillCnt == START_PERIODS - 1) begin
                state <= RUNNING;
            end else begin
                fillCnt <= fillCnt + 1'b1;
            end
        end
    end

    assign ctl.outEn = (state == RUNNING);

    assign ctl.wrBank = periodCnt;
    assign ctl.wrAddr = stepCnt;
    // Newest finished batch
    assign ctl.laBank = periodCnt - bankT'(1);
    // Oldest batch still held, overwritten next period
    assign ctl.procBank = periodCnt - bankT'(BANKS - 1);

    assign ctl.fwdAddr = stepCnt;
    assign ctl.revAddr = addrT'(BATCH_WORDS - 1) - stepCnt;
    assign ctl.batchStart = (stepCnt == '0);
    assign ctl.partSel = periodCnt[0];

endmodule

//--- hdl/sampleBanks.sv
`timescale 1ns/1ns

module sampleBanks import batchTypesPkg::*; (
    input logic clk,
    input logic rstN,
    input sdT sdIn,
    batchCtrlIf.banks ctl,
    output sampleWordT laWord,
    output sampleWordT fwdWord,
    output sampleWordT bwdWord
);

    // Older modulator bits of the word being packed
    logic [WORD_BITS-IN_BITS-1:0] packReg;
    sampleWordT packedWord;
    sampleWordT bankMem [BANKS][BATCH_WORDS];

    // Newest input in the low bits
    assign packedWord = {packReg, sdIn};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            packReg <= '0;
        end else begin
            packReg <= packedWord[WORD_BITS-IN_BITS-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bankMem <= '{default: '0};
        end else if (ctl.dsEn) begin
            bankMem[ctl.wrBank][ctl.wrAddr] <= packedWord;
        end
    end

    // Lookahead runs newest word first
    assign laWord = bankMem[ctl.laBank][ctl.revAddr];

    assign fwdWord = bankMem[ctl.procBank][ctl.fwdAddr];
    assign bwdWord = bankMem[ctl.procBank][ctl.revAddr];

endmodule

//--- hdl/recursionChannel.sv
`timescale 1ns/1ns

module recursionChannel import batchTypesPkg::*, batchCoeffPkg::*; #(
    parameter int CH = 0
) (
    input logic clk,
    input logic rstN,
    batchCtrlIf.chan ctl,
    input sampleWordT laWord,
    input sampleWordT fwdWord,
    input sampleWordT bwdWord,
    output fixT partSum
);

    // Signed sum of the bit coefficients
    function automatic fixT tableSum(input sampleWordT w, input fixT coef [WORD_BITS]);
        fixT acc;
        acc = '0;
        for (int p = 0; p < WORD_BITS; p++) begin
            acc = w[p] ? acc + coef[p] : acc - coef[p];
        end
        return acc;
    endfunction

    fixT fwdRe, fwdIm;
    fixT laRe, laIm;
    fixT bwdRe, bwdIm;
    fixT laSeedRe, laSeedIm;

    fixT laBaseRe, laBaseIm;
    fixT bwdBaseRe, bwdBaseIm;
    fixT fwdNextRe, fwdNextIm;
    fixT laNextRe, laNextIm;
    fixT bwdNextRe, bwdNextIm;
    fixT fwdOut, bwdOut;

    fixT fwdPart [PART_BUFS][BATCH_WORDS];
    fixT bwdPart [PART_BUFS][BATCH_WORDS];
    logic rdSel;

    // Lookahead restarts from zero, backward from the latched lookahead
    assign laBaseRe = ctl.batchStart ? '0 : laRe;
    assign laBaseIm = ctl.batchStart ? '0 : laIm;
    assign bwdBaseRe = ctl.batchStart ? laSeedRe : bwdRe;
    assign bwdBaseIm = ctl.batchStart ? laSeedIm : bwdIm;

    assign fwdNextRe = cplxRe(fwdFactorRe[CH], fwdFactorIm[CH], fwdRe, fwdIm)
                     + tableSum(fwdWord, fwdBitCoefRe[CH]);
    assign fwdNextIm = cplxIm(fwdFactorRe[CH], fwdFactorIm[CH], fwdRe, fwdIm)
                     + tableSum(fwdWord, fwdBitCoefIm[CH]);

    assign laNextRe = cplxRe(bwdFactorRe[CH], bwdFactorIm[CH], laBaseRe, laBaseIm)
                    + tableSum(laWord, bwdBitCoefRe[CH]);
    assign laNextIm = cplxIm(bwdFactorRe[CH], bwdFactorIm[CH], laBaseRe, laBaseIm)
                    + tableSum(laWord, bwdBitCoefIm[CH]);

    assign bwdNextRe = cplxRe(bwdFactorRe[CH], bwdFactorIm[CH], bwdBaseRe, bwdBaseIm)
                     + tableSum(bwdWord, bwdBitCoefRe[CH]);
    assign bwdNextIm = cplxIm(bwdFactorRe[CH], bwdFactorIm[CH], bwdBaseRe, bwdBaseIm)
                     + tableSum(bwdWord, bwdBitCoefIm[CH]);

    // Only the real part of the weighted state is kept
    assign fwdOut = cplxRe(fwdNextRe, fwdNextIm, fwdWeightRe[CH], fwdWeightIm[CH]);
    assign bwdOut = cplxRe(bwdNextRe, bwdNextIm, bwdWeightRe[CH], bwdWeightIm[CH]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fwdRe <= '0;
            fwdIm <= '0;
            laRe <= '0;
            laIm <= '0;
            bwdRe <= '0;
            bwdIm <= '0;
            laSeedRe <= '0;
            laSeedIm <= '0;
        end else if (ctl.dsEn) begin
            fwdRe <= fwdNextRe;
            fwdIm <= fwdNextIm;
            laRe <= laNextRe;
            laIm <= laNextIm;
            bwdRe <= bwdNextRe;
            bwdIm <= bwdNextIm;
            // Last step, lookahead has reached the oldest word
            if (ctl.revAddr == '0) begin
                laSeedRe <= laNextRe;
                laSeedIm <= laNextIm;
            end
        end
    end

    // Backward results land at the reversed address so readback is in time order
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fwdPart <= '{default: '0};
            bwdPart <= '{default: '0};
        end else if (ctl.dsEn) begin
            fwdPart[ctl.partSel][ctl.fwdAddr] <= fwdOut;
            bwdPart[ctl.partSel][ctl.revAddr] <= bwdOut;
        end
    end

    assign rdSel = ~ctl.partSel;
    assign partSum = fwdPart[rdSel][ctl.fwdAddr] + bwdPart[rdSel][ctl.fwdAddr];

endmodule

//--- hdl/batchFilterTop.sv
`timescale 1ns/1ns

module batchFilterTop import batchTypesPkg::*; (
    input logic clk,
    input logic rstN,
    input sdT sdIn,
    output fixT result,
    output logic resultValid
);

    batchCtrlIf ctlBus ();

    sampleWordT laWord;
    sampleWordT fwdWord;
    sampleWordT bwdWord;
    fixT partSum [CHANNELS];
    fixT chanTotal;

    batchControl uCtrl (
        .clk (clk),
        .rstN(rstN),
        .ctl (ctlBus)
    );

    sampleBanks uBanks (
        .clk    (clk),
        .rstN   (rstN),
        .sdIn   (sdIn),
        .ctl    (ctlBus),
        .laWord (laWord),
        .fwdWord(fwdWord),
        .bwdWord(bwdWord)
    );

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : gChan
        recursionChannel #(.CH(ch)) uChan (
            .clk    (clk),
            .rstN   (rstN),
            .ctl    (ctlBus),
            .laWord (laWord),
            .fwdWord(fwdWord),
            .bwdWord(bwdWord),
            .partSum(partSum[ch])
        );
    end

    always_comb begin
        chanTotal = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            chanTotal = chanTotal + partSum[ch];
        end
    end

    // Captured at the end of each sample step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= ctlBus.outEn & ctlBus.dsEn;
            if (ctlBus.dsEn) begin
                result <= chanTotal;
            end
        end
    end

endmodule

//--- test/batchRefModel.svh
// Reference model of the filter output
// Reads the sampled inputs in sdLog and fills expQ in output order

function automatic fixT modelMul(input fixT a, input fixT b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return fixT'(prod >>> FRAC_BITS);
endfunction

// Plus the coefficient for a one bit, minus it for a zero bit
function automatic fixT tableValue(input sampleWordT w, input int ch, input bit fwd,
                                   input bit imag);
    fixT acc;
    fixT c;
    acc = '0;
    for (int p = 0; p < WORD_BITS; p++) begin
        if (fwd) begin
            c = imag ? fwdBitCoefIm[ch][p] : fwdBitCoefRe[ch][p];
        end else begin
            c = imag ? bwdBitCoefIm[ch][p] : bwdBitCoefRe[ch][p];
        end
        acc = w[p] ? acc + c : acc - c;
    end
    return acc;
endfunction

// New state is factor times state plus the table value of the word
task automatic stepState(input int ch, input bit fwd, input sampleWordT w,
                         inout fixT sRe, inout fixT sIm);
    fixT fRe;
    fixT fIm;
    fixT nRe;
    fRe = fwd ? fwdFactorRe[ch] : bwdFactorRe[ch];
    fIm = fwd ? fwdFactorIm[ch] : bwdFactorIm[ch];
    nRe = modelMul(fRe, sRe) - modelMul(fIm, sIm) + tableValue(w, ch, fwd, 1'b0);
    sIm = modelMul(fRe, sIm) + modelMul(fIm, sRe) + tableValue(w, ch, fwd, 1'b1);
    sRe = nRe;
endtask

function automatic fixT weightedRe(input fixT sRe, input fixT sIm, input fixT wRe,
                                   input fixT wIm);
    return modelMul(sRe, wRe) - modelMul(sIm, wIm);
endfunction

task automatic buildExpected();
    sampleWordT padWords[$];
    sampleWordT word;
    fixT fwdOut [BATCH_WORDS];
    fixT fRe, fIm, sRe, sIm;
    int lead;
    int nBatches;
    int idx;
    lead = BANKS - 1;
    nBatches = sdLog.size() / (OSR * BATCH_WORDS);
    expQ.delete();
    // Cleared banks are read as zero batches during startup
    for (int n = 0; n < lead * BATCH_WORDS; n++) begin
        padWords.push_back('0);
    end
    for (int n = 0; n < nBatches * BATCH_WORDS; n++) begin
        word = '0;
        // Oldest input ends up in the high bits
        for (int k = 0; k < OSR; k++) begin
            word = (word << IN_BITS) | sdLog[OSR * n + k];
        end
        padWords.push_back(word);
    end
    // A batch is done once the batch after it is known for the lookahead
    for (int pb = lead; pb + 1 < nBatches + lead; pb++) begin
        for (int j = 0; j < BATCH_WORDS; j++) begin
            expQ.push_back('0);
        end
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
        fRe = '0;
        fIm = '0;
        for (int pb = 0; pb + 1 < nBatches + lead; pb++) begin
            for (int j = 0; j < BATCH_WORDS; j++) begin
                stepState(ch, 1'b1, padWords[pb * BATCH_WORDS + j], fRe, fIm);
                fwdOut[j] = weightedRe(fRe, fIm, fwdWeightRe[ch], fwdWeightIm[ch]);
            end
            if (pb >= lead) begin
                sRe = '0;
                sIm = '0;
                for (int j = BATCH_WORDS - 1; j >= 0; j--) begin
                    stepState(ch, 1'b0, padWords[(pb + 1) * BATCH_WORDS + j], sRe, sIm);
                end
                // Backward pass picks up where the lookahead ended
                for (int j = BATCH_WORDS - 1; j >= 0; j--) begin
                    stepState(ch, 1'b0, padWords[pb * BATCH_WORDS + j], sRe, sIm);
                    idx = (pb - lead) * BATCH_WORDS + j;
                    expQ[idx] = expQ[idx] + fwdOut[j]
                              + weightedRe(sRe, sIm, bwdWeightRe[ch], bwdWeightIm[ch]);
                end
            end
        end
    end
endtask

//--- test/batchFilterTb.sv
`timescale 1ns/1ns

module batchFilterTb import batchTypesPkg::*, batchCoeffPkg::*; ();

    logic clk;
    logic rstN;
    sdT sdIn;
    fixT result;
    logic resultValid;

    integer seed = 32'h8e65_0e60;
    int stimMode;
    int checks;
    int valueErrors;
    int timeoutErrors;
    // Inputs as the DUT samples them
    sdT sdLog[$];
    fixT resQ[$];
    fixT expQ[$];

    `include "batchRefModel.svh"

    batchFilterTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .sdIn       (sdIn),
        .result     (result),
        .resultValid(resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Mode 0 random, otherwise six batches of ones then zeros
    initial begin
        sdIn = '0;
        forever begin
            @(posedge clk);
            #1;
            if (stimMode == 0) begin
                sdIn = sdT'($random(seed));
            end else begin
                sdIn = (sdLog.size() < 6 * OSR * BATCH_WORDS) ? '1 : '0;
            end
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            sdLog.push_back(sdIn);
        end
    end

    always @(negedge clk) begin
        if (rstN && resultValid) begin
            resQ.push_back(result);
        end
    end

    task automatic checkFix(input string name, input fixT expected, input fixT actual);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic applyReset(input int mode);
        @(posedge clk);
        #1;
        rstN = 1'b0;
        stimMode = mode;
        sdLog.delete();
        resQ.delete();
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic waitFirstValid(input string name);
        int cycles;
        cycles = 0;
        while (resultValid !== 1'b1 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (resultValid === 1'b1) begin
            // First step of period START_PERIODS, seen at the following falling edge
            checkCount({name, " first valid"}, OSR * BATCH_WORDS * START_PERIODS + OSR + 1,
                       cycles);
        end else begin
            timeoutErrors++;
            $display("Timeout in %s: resultValid never went high after reset", name);
        end
    endtask

    task automatic waitInputs(input string name, input int count);
        int cycles;
        cycles = 0;
        while (sdLog.size() < count && cycles < count + 100) begin
            @(negedge clk);
            cycles++;
        end
        if (sdLog.size() < count) begin
            timeoutErrors++;
            $display("Timeout in %s: only %0d of %0d inputs applied", name, sdLog.size(), count);
        end
    endtask

    task automatic compareResults(input string name);
        for (int i = 0; i < resQ.size() && i < expQ.size(); i++) begin
            checkFix($sformatf("%s result %0d", name, i), expQ[i], resQ[i]);
        end
        if (resQ.size() > expQ.size()) begin
            valueErrors++;
            $display("%s: the DUT gave more results than the model could predict", name);
        end
    endtask

    task automatic runPhase(input string name, input int mode, input int inputs);
        applyReset(mode);
        waitFirstValid(name);
        waitInputs(name, inputs);
        // Past the falling edge that collects the last pulse
        #2;
        buildExpected();
        if (inputs % (OSR * BATCH_WORDS) == 0) begin
            checkCount({name, " count"},
                       (inputs / (OSR * BATCH_WORDS) - START_PERIODS) * BATCH_WORDS,
                       resQ.size());
        end
        compareResults(name);
    endtask

    initial begin
        rstN = 1'b0;
        stimMode = 0;
        checks = 0;
        valueErrors = 0;
        timeoutErrors = 0;
        runPhase("random", 0, 44 * OSR * BATCH_WORDS);
        runPhase("onesZeros", 1, 14 * OSR * BATCH_WORDS);
        // Stops in the middle of a batch, the next reset cuts the stream
        runPhase("midStream", 0, 9 * OSR * BATCH_WORDS + 7);
        runPhase("afterReset", 0, 12 * OSR * BATCH_WORDS);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, valueErrors,
                 timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+test
hdl/batchTypesPkg.sv
hdl/batchCoeffPkg.sv
hdl/batchCtrlIf.sv
hdl/batchControl.sv
hdl/sampleBanks.sv
hdl/recursionChannel.sv
hdl/batchFilterTop.sv
test/batchFilterTb.sv

//--- Bender.yml
package:
  name: batch_filter

sources:
  - hdl/batchTypesPkg.sv
  - hdl/batchCoeffPkg.sv
  - hdl/batchCtrlIf.sv
  - hdl/batchControl.sv
  - hdl/sampleBanks.sv
  - hdl/recursionChannel.sv
  - hdl/batchFilterTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/batchFilterTb.sv
